// File: common/pixel_pkg.sv
`default_nettype none

package pixel_pkg;

    // One RGB pixel, three 8-bit channels
    typedef logic [23:0] pixel_t;

    // Position inside a µblock
    typedef logic [2:0] pix_col_t;
    typedef logic [3:0] pix_line_t;

    // Position of the µblock inside the slice
    typedef logic [2:0] blk_col_t;
    typedef logic [1:0] blk_line_t;

    // Packed as-is into the slice-store address
    typedef struct packed {
        pix_col_t  pixel_col;
        pix_line_t pixel_line;
        blk_col_t  block_col;
        blk_line_t block_line;
    } pixel_coord_t;

    typedef struct packed {
        pixel_t       data;
        logic         valid;
        pixel_coord_t coord;
    } framed_pixel_t;

    typedef struct packed {
        pixel_t    mean;
        blk_col_t  block_col;
        blk_line_t block_line;
    } block_mean_t;

endpackage

`default_nettype wire

// File: common/frame_pkg.sv
`default_nettype none

package frame_pkg;

    // Slice geometry, in pixels, lines and µblocks
    localparam int unsigned px_per_block_col = 8;
    localparam int unsigned lines_per_block  = 16;
    localparam int unsigned blocks_per_row   = 5;
    localparam int unsigned block_rows       = 3;

    typedef logic [11:0] slice_addr_t;

    // Word as delivered by the camera port
    typedef struct packed {
        logic [23:0] rgb;
        logic        hsync;
        logic        vsync;
    } cam_word_t;

    typedef logic [7:0] slice_cnt_t;

endpackage

`default_nettype wire

// File: camera_fifo/camera_fifo.sv
`default_nettype none

module camera_fifo import frame_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic      clk,
    input  logic      nrst,
    input  logic      wr,
    input  cam_word_t wdata,
    output cam_word_t head,
    output logic      empty,
    output logic      full
);

    localparam int ptr_w = $clog2(fifo_depth);

    // Extra top bit tells full from empty
    typedef logic [ptr_w:0] ptr_t;

    cam_word_t mem [fifo_depth];
    ptr_t      wr_ptr;
    ptr_t      rd_ptr;
    logic      push;
    logic      pop;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ptr_w] != rd_ptr[ptr_w]) &&
                   (wr_ptr[ptr_w-1:0] == rd_ptr[ptr_w-1:0]);

    // Words arriving while full are lost
    assign push = wr && !full;

    // The framer takes a word every cycle one is present
    assign pop = !empty;

    // First word falls through to the head
    assign head = mem[rd_ptr[ptr_w-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[ptr_w-1:0]] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rgb_logic.sv
`default_nettype none

module rgb_logic import pixel_pkg::*, frame_pkg::*; (
    input  logic          clk,
    input  logic          nrst,
    input  cam_word_t     head,
    input  logic          empty,
    input  logic          rgb_enable,
    output framed_pixel_t framed,
    output slice_cnt_t    wslice_cnt
);

    pixel_coord_t coord;
    slice_cnt_t   slice_cnt;
    logic         vsync_r;
    logic         enable_q;
    logic         consume;
    logic         frame_start;
    logic         active;
    logic         pcol_end;
    logic         bcol_end;
    logic         pline_end;
    logic         bline_end;

    assign consume     = !empty;
    assign frame_start = head.vsync && !vsync_r;
    assign active      = head.hsync && head.vsync;

    // Wrap points of the nested counters
    assign pcol_end  = (coord.pixel_col == pix_col_t'(px_per_block_col - 1));
    assign bcol_end  = (coord.block_col == blk_col_t'(blocks_per_row - 1));
    assign pline_end = (coord.pixel_line == pix_line_t'(lines_per_block - 1));
    assign bline_end = (coord.block_line == blk_line_t'(block_rows - 1));

    // Byte swap, low input byte ends up on top
    assign framed.data  = {head.rgb[7:0], head.rgb[15:8], head.rgb[23:16]};
    assign framed.valid = consume && active && enable_q;
    assign framed.coord = coord;
    assign wslice_cnt   = slice_cnt;

    // Coordinates advance on every active word, enabled or not
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            coord     <= '0;
            slice_cnt <= '0;
        end else if (consume) begin
            if (frame_start) begin
                coord     <= '0;
                slice_cnt <= '0;
            end else if (active) begin
                coord.pixel_col <= coord.pixel_col + 1'b1;
                if (pcol_end) begin
                    coord.pixel_col <= '0;
                    coord.block_col <= coord.block_col + 1'b1;
                    if (bcol_end) begin
                        coord.block_col  <= '0;
                        coord.pixel_line <= coord.pixel_line + 1'b1;
                        if (pline_end) begin
                            coord.pixel_line <= '0;
                            coord.block_line <= coord.block_line + 1'b1;
                            if (bline_end) begin
                                coord.block_line <= '0;
                                slice_cnt        <= slice_cnt + 1'b1;
                            end
                        end
                    end
                end
            end
        end
    end

    // Previous consumed vsync, for the frame start edge
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            vsync_r <= 1'b0;
        end else if (consume) begin
            vsync_r <= head.vsync;
        end
    end

    // Enable is held for the whole frame
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            enable_q <= 1'b0;
        end else if (consume && frame_start) begin
            enable_q <= rgb_enable;
        end
    end

endmodule

`default_nettype wire

// File: block_store/block_store.sv
`default_nettype none

module block_store import pixel_pkg::*, frame_pkg::*; (
    input  logic          clk,
    input  logic          nrst,
    input  framed_pixel_t framed,
    input  slice_addr_t   rd_addr,
    output pixel_t        rd_data,
    output logic          slice_done
);

    // Sparse map from the coordinate bits, 1920 entries per bank hold pixels
    localparam int bank_words = 2 ** $bits(slice_addr_t);

    pixel_t      bank_mem [2][bank_words];
    logic        wr_bank;
    slice_addr_t wr_addr;
    logic        last_pixel;

    assign wr_addr = slice_addr_t'(framed.coord);

    // Bottom right pixel of the last µblock closes the slice
    assign last_pixel =
        framed.valid &&
        (framed.coord.pixel_col  == pix_col_t'(px_per_block_col - 1)) &&
        (framed.coord.pixel_line == pix_line_t'(lines_per_block - 1)) &&
        (framed.coord.block_col  == blk_col_t'(blocks_per_row - 1)) &&
        (framed.coord.block_line == blk_line_t'(block_rows - 1));

    // Write side fills one bank, reader sees the other
    always_ff @(posedge clk) begin
        if (framed.valid) begin
            bank_mem[wr_bank][wr_addr] <= framed.data;
        end
        rd_data <= bank_mem[~wr_bank][rd_addr];
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_bank    <= 1'b0;
            slice_done <= 1'b0;
        end else begin
            slice_done <= last_pixel;
            if (last_pixel) begin
                wr_bank <= ~wr_bank;
            end
        end
    end

endmodule

`default_nettype wire

// File: block_store/block_mean.sv
`default_nettype none

module block_mean import pixel_pkg::*, frame_pkg::*; (
    input  logic          clk,
    input  logic          nrst,
    input  framed_pixel_t framed,
    output logic          mean_valid,
    output block_mean_t   mean_out
);

    // 128 pixels of up to 255 fit in 15 bits
    localparam int sum_w      = 15;
    localparam int mean_shift = $clog2(px_per_block_col * lines_per_block);

    typedef logic [sum_w-1:0] chan_sum_t;

    typedef struct packed {
        chan_sum_t hi;
        chan_sum_t mid;
        chan_sum_t lo;
    } rgb_sum_t;

    rgb_sum_t sums [blocks_per_row];
    rgb_sum_t base;
    rgb_sum_t next_sum;
    blk_col_t col;
    logic     first_pixel;
    logic     last_pixel;

    function automatic logic [7:0] chan_mean(chan_sum_t sum);
        chan_sum_t shifted;
        shifted = sum >> mean_shift;
        return shifted[7:0];
    endfunction

    assign col = framed.coord.block_col;

    assign first_pixel = (framed.coord.pixel_col == '0) &&
                         (framed.coord.pixel_line == '0);
    assign last_pixel  =
        (framed.coord.pixel_col  == pix_col_t'(px_per_block_col - 1)) &&
        (framed.coord.pixel_line == pix_line_t'(lines_per_block - 1));

    // A block's first pixel drops anything left by an interrupted frame
    assign base = first_pixel ? '0 : sums[col];

    assign next_sum.hi  = base.hi  + chan_sum_t'(framed.data[23:16]);
    assign next_sum.mid = base.mid + chan_sum_t'(framed.data[15:8]);
    assign next_sum.lo  = base.lo  + chan_sum_t'(framed.data[7:0]);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < blocks_per_row; i++) begin
                sums[i] <= '0;
            end
            mean_valid <= 1'b0;
        end else begin
            mean_valid <= 1'b0;
            if (framed.valid) begin
                if (last_pixel) begin
                    sums[col]  <= '0;
                    mean_valid <= 1'b1;
                end else begin
                    sums[col] <= next_sum;
                end
            end
        end
    end

    // Result register, loaded with the block just closed
    always_ff @(posedge clk) begin
        if (framed.valid && last_pixel) begin
            mean_out.mean       <= {chan_mean(next_sum.hi),
                                    chan_mean(next_sum.mid),
                                    chan_mean(next_sum.lo)};
            mean_out.block_col  <= framed.coord.block_col;
            mean_out.block_line <= framed.coord.block_line;
        end
    end

endmodule

`default_nettype wire

// File: verilog/image_slicer_top.sv
`default_nettype none

module image_slicer_top import pixel_pkg::*, frame_pkg::*; #(
    parameter int fifo_depth = 16
) (
    input  logic        clk,
    input  logic        nrst,

    // Camera port
    input  logic        cam_wr,
    input  cam_word_t   cam_word,
    output logic        cam_full,

    input  logic        rgb_enable,

    // Slice read port
    input  slice_addr_t rd_addr,
    output pixel_t      rd_data,
    output logic        slice_done,

    output logic        mean_valid,
    output block_mean_t mean_out,
    output slice_cnt_t  wslice_cnt
);

    cam_word_t     fifo_head;
    logic          fifo_empty;
    framed_pixel_t framed;

    camera_fifo #(
        .fifo_depth (fifo_depth)
    ) i_fifo (
        .clk   (clk),
        .nrst  (nrst),
        .wr    (cam_wr),
        .wdata (cam_word),
        .head  (fifo_head),
        .empty (fifo_empty),
        .full  (cam_full)
    );

    rgb_logic i_framer (
        .clk        (clk),
        .nrst       (nrst),
        .head       (fifo_head),
        .empty      (fifo_empty),
        .rgb_enable (rgb_enable),
        .framed     (framed),
        .wslice_cnt (wslice_cnt)
    );

    block_store i_store (
        .clk        (clk),
        .nrst       (nrst),
        .framed     (framed),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .slice_done (slice_done)
    );

    block_mean i_mean (
        .clk        (clk),
        .nrst       (nrst),
        .framed     (framed),
        .mean_valid (mean_valid),
        .mean_out   (mean_out)
    );

endmodule

`default_nettype wire

// File: testbench/slicer_checker.sv
`default_nettype none

module slicer_checker import pixel_pkg::*, frame_pkg::*; (
    input  logic         clk,
    input  logic         test_start,
    input  logic         test_done,
    input  logic [127:0] test_name,
    input  int           test_mode,
    input  pixel_t       test_base,
    input  logic         test_enable,
    input  pixel_t       test_mean0,
    input  slice_cnt_t   test_slices,
    input  logic         mean_valid,
    input  block_mean_t  mean_out,
    input  logic         slice_done,
    input  slice_cnt_t   wslice_cnt,
    input  logic         cam_full,
    input  logic         rd_en,
    input  slice_addr_t  rd_addr,
    input  pixel_t       rd_data,
    output int           tests_run,
    output int           tests_failed,
    output int           errors_total
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int blocks = blocks_per_row * block_rows;

    int          mean_idx;
    int          done_cnt;
    int          test_errors;
    logic        in_test;
    logic        full_reported;
    logic        rd_pending;
    slice_addr_t rd_addr_q;
    pixel_t      exp_pixel;

    initial begin
        tests_run     = 0;
        tests_failed  = 0;
        errors_total  = 0;
        mean_idx      = 0;
        done_cnt      = 0;
        test_errors   = 0;
        in_test       = 1'b0;
        full_reported = 1'b0;
        rd_pending    = 1'b0;
    end

    function automatic pixel_t swap_bytes(input pixel_t p);
        return {p[7:0], p[15:8], p[23:16]};
    endfunction

    // Gradient modes add the slice column x to the low camera byte
    function automatic pixel_t camera_pixel(input int x);
        if (test_mode == 0) begin
            return test_base;
        end
        return test_base + pixel_t'(x);
    endfunction

    function automatic int column_of(input slice_addr_t a);
        pixel_coord_t c;
        c = pixel_coord_t'(a);
        return int'(c.block_col) * px_per_block_col + int'(c.pixel_col);
    endfunction

    // Every column repeats on all 16 lines, so the line average drops out
    function automatic pixel_t expected_mean(input int blk);
        int     hi;
        int     mid;
        int     lo;
        int     c;
        pixel_t p;
        hi  = 0;
        mid = 0;
        lo  = 0;
        for (c = 0; c < px_per_block_col; c++) begin
            p = swap_bytes(camera_pixel(blk * px_per_block_col + c));
            hi  += int'(p[23:16]);
            mid += int'(p[15:8]);
            lo  += int'(p[7:0]);
        end
        return {8'(hi / px_per_block_col), 8'(mid / px_per_block_col),
                8'(lo / px_per_block_col)};
    endfunction

    task automatic record_error(input string msg);
        $display("%s", msg);
        test_errors++;
        errors_total++;
    endtask

    task automatic check_mean();
        int exp_col;
        int exp_line;
        exp_col  = mean_idx % blocks_per_row;
        exp_line = mean_idx / blocks_per_row;
        if (!test_enable || mean_idx >= blocks) begin
            record_error($sformatf("Unexpected mean result number %0d in %0s (enable %0b)",
                                   mean_idx, test_name, test_enable));
        end else begin
            if (mean_out.block_col != blk_col_t'(exp_col) ||
                mean_out.block_line != blk_line_t'(exp_line)) begin
                record_error($sformatf(
                    "Mismatch %0s block position: expected %0d,%0d, actual %0d,%0d",
                    test_name, exp_col, exp_line, mean_out.block_col, mean_out.block_line));
            end
            exp_pixel = expected_mean(exp_col);
            if (mean_out.mean !== exp_pixel) begin
                record_error($sformatf(
                    "Mismatch %0s mean of block %0d: expected %06h, actual %06h",
                    test_name, mean_idx, exp_pixel, mean_out.mean));
            end
            if (mean_idx == 0 && mean_out.mean !== test_mean0) begin
                record_error($sformatf(
                    "Mismatch %0s block 0 mean vs file: expected %06h, actual %06h",
                    test_name, test_mean0, mean_out.mean));
            end
        end
        mean_idx++;
    endtask

    task automatic close_test();
        int exp_means;
        int exp_done;
        exp_means = test_enable ? blocks : 0;
        exp_done  = test_enable ? 1 : 0;
        if (mean_idx != exp_means) begin
            record_error($sformatf("Mismatch %0s mean count: expected %0d, actual %0d",
                                   test_name, exp_means, mean_idx));
        end
        if (done_cnt != exp_done) begin
            record_error($sformatf("Mismatch %0s slice_done pulses: expected %0d, actual %0d",
                                   test_name, exp_done, done_cnt));
        end
        if (wslice_cnt != test_slices) begin
            record_error($sformatf("Mismatch %0s slice count: expected %0d, actual %0d",
                                   test_name, test_slices, wslice_cnt));
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %0s", test_name);
        end else begin
            tests_failed++;
            $display("FAIL %0s with %0d errors", test_name, test_errors);
        end
    endtask

    // DUT outputs are registers, so the values seen here were settled a cycle ago
    always @(posedge clk) begin
        if (test_start) begin
            mean_idx      = 0;
            done_cnt      = 0;
            test_errors   = 0;
            in_test       = 1'b1;
            full_reported = 1'b0;
        end
        if (mean_valid) begin
            check_mean();
        end
        if (slice_done) begin
            done_cnt++;
        end
        // At most one word per cycle in and one out, so the FIFO never fills
        if (in_test && cam_full !== 1'b0 && !full_reported) begin
            record_error($sformatf("Mismatch %0s cam_full: expected 0, actual %0b",
                                   test_name, cam_full));
            full_reported = 1'b1;
        end
        if (rd_pending) begin
            exp_pixel = swap_bytes(camera_pixel(column_of(rd_addr_q)));
            if (rd_data !== exp_pixel) begin
                record_error($sformatf("Mismatch %0s read at %03h: expected %06h, actual %06h",
                                       test_name, rd_addr_q, exp_pixel, rd_data));
            end
        end
        if (test_done) begin
            close_test();
            in_test = 1'b0;
        end
        rd_pending = rd_en;
        rd_addr_q  = rd_addr;
    end

endmodule

`default_nettype wire

// File: testbench/tb_image_slicer.sv
`default_nettype none

module tb_image_slicer import pixel_pkg::*, frame_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int slice_w    = px_per_block_col * blocks_per_row;
    localparam int slice_h    = lines_per_block * block_rows;
    localparam int wait_limit = 200;

    logic         clk = 1'b0;
    logic         nrst;
    logic         cam_wr;
    cam_word_t    cam_word;
    logic         cam_full;
    logic         rgb_enable;
    slice_addr_t  rd_addr;
    pixel_t       rd_data;
    logic         slice_done;
    logic         mean_valid;
    block_mean_t  mean_out;
    slice_cnt_t   wslice_cnt;

    // Current test as seen by the checker
    logic         test_start;
    logic         test_done;
    logic         rd_en;
    logic [127:0] test_name;
    int           test_mode;
    pixel_t       test_base;
    logic         test_enable;
    pixel_t       test_mean0;
    slice_cnt_t   test_slices;
    int           tests_run;
    int           tests_failed;
    int           errors_total;
    int           seed = 32'h9fd2;
    logic         run_error;

    always #4 clk = ~clk;

    image_slicer_top i_dut (
        .clk        (clk),
        .nrst       (nrst),
        .cam_wr     (cam_wr),
        .cam_word   (cam_word),
        .cam_full   (cam_full),
        .rgb_enable (rgb_enable),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .slice_done (slice_done),
        .mean_valid (mean_valid),
        .mean_out   (mean_out),
        .wslice_cnt (wslice_cnt)
    );

    slicer_checker i_check (
        .clk          (clk),
        .test_start   (test_start),
        .test_done    (test_done),
        .test_name    (test_name),
        .test_mode    (test_mode),
        .test_base    (test_base),
        .test_enable  (test_enable),
        .test_mean0   (test_mean0),
        .test_slices  (test_slices),
        .mean_valid   (mean_valid),
        .mean_out     (mean_out),
        .slice_done   (slice_done),
        .wslice_cnt   (wslice_cnt),
        .cam_full     (cam_full),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .errors_total (errors_total)
    );

    // Mode 0 is a flat colour and all other modes add the slice column
    function automatic pixel_t pixel_colour(input int mode, input pixel_t base, input int x);
        if (mode == 0) begin
            return base;
        end
        return base + pixel_t'(x);
    endfunction

    task automatic write_word(input cam_word_t w);
        int n;
        @(negedge clk);
        if (test_mode == 2) begin
            cam_wr = 1'b0;
            n = $random(seed) & 3;
            repeat (n) @(negedge clk);
        end
        n = 0;
        while (cam_full && n < wait_limit) begin
            cam_wr = 1'b0;
            @(negedge clk);
            n++;
        end
        if (cam_full) begin
            $display("Timeout: camera FIFO stayed full for %0d cycles", wait_limit);
            run_error = 1'b1;
            cam_wr = 1'b0;
        end else begin
            cam_wr   = 1'b1;
            cam_word = w;
        end
    endtask

    // Blanking word with vsync low, then the vsync rising edge, then the pixels
    task automatic send_frame(input int mode, input pixel_t base, input int pixels);
        cam_word_t w;
        int        k;
        w = '0;
        write_word(w);
        w.vsync = 1'b1;
        write_word(w);
        w.hsync = 1'b1;
        for (k = 0; k < pixels && !run_error; k++) begin
            w.rgb = pixel_colour(mode, base, k % slice_w);
            write_word(w);
        end
        @(negedge clk);
        cam_wr = 1'b0;
    endtask

    task automatic wait_for_slice(input slice_cnt_t target);
        int n;
        n = 0;
        while (wslice_cnt != target && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (wslice_cnt != target) begin
            $display("Timeout: slice counter stuck at %0d while waiting for %0d",
                     wslice_cnt, target);
            run_error = 1'b1;
        end
    endtask

    task automatic read_samples(input int count);
        pixel_coord_t c;
        int           x;
        int           y;
        int           i;
        for (i = 0; i < count; i++) begin
            x = $unsigned($random(seed)) % slice_w;
            y = $unsigned($random(seed)) % slice_h;
            c.pixel_col  = pix_col_t'(x % px_per_block_col);
            c.block_col  = blk_col_t'(x / px_per_block_col);
            c.pixel_line = pix_line_t'(y % lines_per_block);
            c.block_line = blk_line_t'(y / lines_per_block);
            @(negedge clk);
            rd_en   = 1'b1;
            rd_addr = slice_addr_t'(c);
        end
        @(negedge clk);
        rd_en = 1'b0;
    endtask

    task automatic run_test(input int en, input int slices);
        @(negedge clk);
        test_enable = (en != 0);
        test_slices = slice_cnt_t'(slices);
        rgb_enable  = (en != 0);
        test_start  = 1'b1;
        @(negedge clk);
        test_start = 1'b0;
        // Restart case sends a partial frame that closes no block before the full one
        if (test_mode == 4) begin
            send_frame(0, ~test_base, 300);
        end
        send_frame(test_mode, test_base, slice_w * slice_h);
        wait_for_slice(test_slices);
        if (test_mode == 3 && !run_error) begin
            read_samples(24);
        end
        @(negedge clk);
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        string line;
        int    fd;
        int    fields;
        int    en;
        int    slices;
        nrst        = 1'b0;
        cam_wr      = 1'b0;
        cam_word    = '0;
        rgb_enable  = 1'b0;
        rd_addr     = '0;
        rd_en       = 1'b0;
        test_start  = 1'b0;
        test_done   = 1'b0;
        test_name   = '0;
        test_mode   = 0;
        test_base   = '0;
        test_enable = 1'b0;
        test_mean0  = '0;
        test_slices = '0;
        run_error   = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        fd = $fopen("testbench/slicer_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open testbench/slicer_patterns.txt");
            run_error = 1'b1;
        end else begin
            // Comment lines stop the scan after the first field
            while (!run_error && $fgets(line, fd) != 0) begin
                fields = $sscanf(line, "%s %d %h %d %h %d", test_name, test_mode,
                                 test_base, en, test_mean0, slices);
                if (fields == 6) begin
                    run_test(en, slices);
                end
            end
            $fclose(fd);
        end

        @(negedge clk);
        $display("Summary: %0d tests run, %0d failed, %0d errors", tests_run,
                 tests_failed, errors_total);
        if (!run_error && tests_run > 0 && tests_failed == 0 && errors_total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/slicer_patterns.txt
# Columns: name, mode, camera rgb base (hex), enable, block 0 mean (hex), slice count
# Modes: 0 flat, 1 gradient, 2 gradient with gaps, 3 gradient and read-back, 4 vsync restart
const_mid      0 123456 1 563412 1
const_max      0 ff00a5 1 a500ff 1
grad_basic     1 102030 1 332010 1
grad_high      1 aabbc8 1 cbbbaa 1
enable_low     1 102030 0 000000 1
enable_back    0 000000 1 000000 1
grad_gaps      2 102030 1 332010 1
readback       3 0a0b0c 1 0f0b0a 1
vsync_restart  4 405060 1 635040 1

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_image_slicer -f vlog.f -o sim_image_slicer
./obj_dir/sim_image_slicer | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

// File: vlog.f
common/pixel_pkg.sv
common/frame_pkg.sv
camera_fifo/camera_fifo.sv
verilog/rgb_logic.sv
block_store/block_store.sv
block_store/block_mean.sv
verilog/image_slicer_top.sv
testbench/slicer_checker.sv
testbench/tb_image_slicer.sv
